// ==== dv/tb_clock_gen.sv ====
// testbench clock and reset source
// 20 ns clock, synchronous reset held high for the first 5 cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #2 rst_o = 1'b0;   // released just after the 5th edge
    end

endmodule

// ==== dv/tb_token_engine.sv ====
// token engine testbench
// GLB memory slave with random wait states, show-ahead opsum FIFO models,
// random ifmap full flags and directed tests over two passes
`timescale 1ns/10ps

module tb_token_engine;
    import token_pkg::*;

    localparam int LANES    = 4;
    localparam int MEM_W    = 1024;
    localparam int MAX_ROWS = 5;
    // two passes of weight reads plus rows*LANES reads and writes, each up to
    // 3 wait states, arbitration, full stalls and register traffic, with margin
    localparam int TIMEOUT_CYCLES = 2 * (LANES + 2 * MAX_ROWS * LANES) * 40 + 2000;

    logic clk, rst;
    logic wbs_cyc, wbs_stb, wbs_we;
    logic [2:0] wbs_adr;
    logic [DATA_W-1:0] wbs_dat_w, wbs_dat_r;
    logic wbs_ack;
    logic glb_cyc, glb_stb, glb_we, glb_ack;
    logic [ADDR_W-1:0] glb_adr;
    logic [3:0] glb_sel;
    logic [DATA_W-1:0] glb_dat_w, glb_dat_r;
    weight_load_t wload;
    logic [LANES-1:0] ifmap_push, ifmap_full, opsum_pop, opsum_empty;
    logic [DATA_W-1:0] ifmap_push_data;
    logic [LANES-1:0][DATA_W-1:0] opsum_pop_data;

    logic [DATA_W-1:0] mem [MEM_W];
    logic [DATA_W-1:0] opq [LANES][$];     // FIFO contents seen by the DUT
    logic [DATA_W-1:0] exp_op [LANES][$];  // what should land in GLB
    logic [31:0] seed = 32'd30990;
    int errors = 0;
    int cycles = 0;
    int wcount;
    int push_cnt [LANES];
    int wait_left = -1;
    logic [ADDR_W-1:0] cur_wbase, cur_ibase, cur_obase;
    int cur_rows;

    tb_clock_gen u_clock_gen (.clk_o(clk), .rst_o(rst));

    token_engine #(.LANES(LANES)) uut (
        .clk(clk), .rst_i(rst),
        .wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb), .wbs_we_i(wbs_we),
        .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w),
        .wbs_dat_o(wbs_dat_r), .wbs_ack_o(wbs_ack),
        .glb_cyc_o(glb_cyc), .glb_stb_o(glb_stb), .glb_we_o(glb_we),
        .glb_adr_o(glb_adr), .glb_sel_o(glb_sel), .glb_dat_o(glb_dat_w),
        .glb_dat_i(glb_dat_r), .glb_ack_i(glb_ack),
        .weight_load_o(wload),
        .ifmap_push_o(ifmap_push), .ifmap_push_data_o(ifmap_push_data),
        .ifmap_full_i(ifmap_full),
        .opsum_pop_o(opsum_pop), .opsum_empty_i(opsum_empty),
        .opsum_pop_data_i(opsum_pop_data)
    );

    function logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // initial GLB contents, every address bit takes part
    function logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function int mem_idx(input logic [ADDR_W-1:0] a);
        return int'(a % MEM_W);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // GLB slave, FIFO models and monitors; sample mid-cycle, drive after the edge
    always begin
        logic [LANES-1:0] pops_s;
        logic req_s;
        @(negedge clk);
        pops_s = opsum_pop;
        req_s  = glb_cyc && glb_stb && !glb_ack;
        if (!rst) begin
            if (req_s) begin
                check_eq("glb_sel", 32'hf, 32'(glb_sel));
            end
            for (int l = 0; l < LANES; l++) begin
                assert (!(opsum_pop[l] && opsum_empty[l])) else begin
                    $display("pop issued on empty opsum lane %0d", l);
                    errors++;
                end
                assert (!(ifmap_push[l] && ifmap_full[l])) else begin
                    $display("push issued on full ifmap lane %0d", l);
                    errors++;
                end
                if (ifmap_push[l]) begin
                    check_eq("ifmap_stream",
                             fill_word(cur_ibase + ADDR_W'(push_cnt[l] * LANES + l)),
                             ifmap_push_data);
                    push_cnt[l]++;
                end
            end
            if (wload.en) begin
                check_eq("weight_load row", wcount, 32'(wload.row));
                check_eq("weight_load", fill_word(cur_wbase + ADDR_W'(wcount)), wload.data.word);
                wcount++;
            end
        end
        @(posedge clk);
        #2;
        glb_ack = 1'b0;
        if (req_s) begin
            if (wait_left < 0) wait_left = int'(next_rand() >> 16) % 4;
            if (wait_left == 0) begin
                if (glb_we) mem[mem_idx(glb_adr >> 2)] = glb_dat_w;
                else glb_dat_r = mem[mem_idx(glb_adr >> 2)];
                glb_ack   = 1'b1;
                wait_left = -1;
            end else begin
                wait_left--;
            end
        end
        for (int l = 0; l < LANES; l++) begin
            if (pops_s[l] && opq[l].size() > 0) void'(opq[l].pop_front());
            // data held back on some cycles so the drainer meets empty lanes
            opsum_empty[l]    = (opq[l].size() == 0) || (((next_rand() >> 20) % 4) == 1);
            opsum_pop_data[l] = (opq[l].size() > 0) ? opq[l][0] : '0;
            ifmap_full[l]     = ((next_rand() >> 20) % 4) == 0;
        end
    end

    // cycle limit for the whole run
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, pass never finished", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        wbs_we    = we;
        wbs_adr   = adr;
        wbs_dat_w = wdat;
        do @(negedge clk); while (!wbs_ack);
        rdat = wbs_dat_r;
        @(posedge clk);
        #2;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic register_rw();
        logic [31:0] rd;
        wb_access(1'b0, REG_STATUS, 0, rd);
        check_eq("register_rw status", 0, rd);
        for (int r = 2; r <= 5; r++) begin
            wb_access(1'b1, 3'(r), 32'h1000 * r + 32'h37, rd);
        end
        for (int r = 2; r <= 4; r++) begin
            wb_access(1'b0, 3'(r), 0, rd);
            check_eq("register_rw base", 32'h1000 * r + 32'h37, rd);
        end
        wb_access(1'b0, REG_ROWS, 0, rd);
        check_eq("register_rw rows", 32'h5037, rd);
    endtask

    // one pass, including the busy, ignored start and done checks
    task automatic run_pass(input logic [31:0] wb, input logic [31:0] ib,
                            input logic [31:0] ob, input int rows);
        logic [31:0] rd;
        logic [31:0] v;
        cur_wbase = wb;
        cur_ibase = ib;
        cur_obase = ob;
        cur_rows  = rows;
        wcount    = 0;
        for (int l = 0; l < LANES; l++) begin
            push_cnt[l] = 0;
            exp_op[l].delete();
            for (int r = 0; r < rows; r++) begin
                v = next_rand();
                opq[l].push_back(v);
                exp_op[l].push_back(v);
            end
        end
        wb_access(1'b1, REG_WEIGHT_BASE, wb, rd);
        wb_access(1'b1, REG_IFMAP_BASE, ib, rd);
        wb_access(1'b1, REG_OPSUM_BASE, ob, rd);
        wb_access(1'b1, REG_ROWS, rows, rd);
        wb_access(1'b1, REG_CTRL, 1, rd);
        wb_access(1'b0, REG_STATUS, 0, rd);
        check_eq("done_restart busy at start", 32'h1, rd);  // busy, old done cleared
        wb_access(1'b1, REG_CTRL, 1, rd);                   // ignored while busy
        do wb_access(1'b0, REG_STATUS, 0, rd); while (!rd[1]);
        check_eq("done_restart end status", 32'h2, rd);
        repeat (4) @(posedge clk);
        #2;
        wb_access(1'b0, REG_STATUS, 0, rd);
        check_eq("done_restart no restart", 32'h2, rd);
    endtask

    task automatic check_weight_load();
        check_eq("weight_load count", LANES, wcount);
    endtask

    task automatic check_ifmap_stream();
        for (int l = 0; l < LANES; l++) begin
            check_eq("ifmap_stream lane count", cur_rows, push_cnt[l]);
        end
    endtask

    task automatic check_opsum_drain();
        for (int l = 0; l < LANES; l++) begin
            check_eq("opsum_drain left in fifo", 0, opq[l].size());
            for (int r = 0; r < cur_rows; r++) begin
                check_eq("opsum_drain", exp_op[l][r],
                         mem[mem_idx(cur_obase + ADDR_W'(r * LANES + l))]);
            end
        end
    endtask

    task automatic done_restart();
        run_pass(32'd40, 32'd160, 32'd600, MAX_ROWS);
        check_weight_load();
        check_ifmap_stream();
        check_opsum_drain();
    endtask

    initial begin
        wbs_cyc        = 1'b0;
        wbs_stb        = 1'b0;
        wbs_we         = 1'b0;
        wbs_adr        = '0;
        wbs_dat_w      = '0;
        glb_ack        = 1'b0;
        glb_dat_r      = '0;
        ifmap_full     = '0;
        opsum_empty    = '1;
        opsum_pop_data = '0;
        for (int i = 0; i < MEM_W; i++) mem[i] = fill_word(ADDR_W'(i));
        @(negedge rst);
        @(posedge clk);
        #2;
        register_rw();
        run_pass(32'd16, 32'd64, 32'd300, 3);
        check_weight_load();
        check_ifmap_stream();
        check_opsum_drain();
        done_restart();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/cfg_regs.sv ====
// configuration registers on a wishbone classic slave port
// holds the pass bases and row count, fires start, keeps a sticky done
`timescale 1ns/10ps

module cfg_regs (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         wbs_cyc_i,
    input  logic                         wbs_stb_i,
    input  logic                         wbs_we_i,
    input  logic [2:0]                   wbs_adr_i,
    input  logic [token_pkg::DATA_W-1:0] wbs_dat_i,
    output logic [token_pkg::DATA_W-1:0] wbs_dat_o,
    output logic                         wbs_ack_o,
    input  logic                         busy_i,
    input  logic                         pass_done_i,
    output token_pkg::pass_cfg_t         cfg_o,
    output logic                         start_o
);
    import token_pkg::*;

    logic wb_hit;
    logic done_q;

    assign wb_hit = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;  // skip the ack cycle

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wbs_ack_o <= 1'b0;
            start_o   <= 1'b0;
            done_q    <= 1'b0;
            cfg_o     <= '0;
        end else begin
            wbs_ack_o <= wb_hit;
            start_o   <= wb_hit && wbs_we_i && (wbs_adr_i == REG_CTRL) && wbs_dat_i[0]
                         && !busy_i;
            if (start_o) begin
                done_q <= 1'b0;
            end else if (pass_done_i) begin
                done_q <= 1'b1;  // sticky until next start
            end
            if (wb_hit && wbs_we_i) begin
                case (wbs_adr_i)
                    REG_WEIGHT_BASE: cfg_o.weight_base <= wbs_dat_i;
                    REG_IFMAP_BASE:  cfg_o.ifmap_base  <= wbs_dat_i;
                    REG_OPSUM_BASE:  cfg_o.opsum_base  <= wbs_dat_i;
                    REG_ROWS:        cfg_o.rows        <= wbs_dat_i[ROW_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read data, valid with ack
    always_ff @(posedge clk) begin
        if (wb_hit) begin
            case (wbs_adr_i)
                REG_STATUS:      wbs_dat_o <= DATA_W'({done_q, busy_i});
                REG_WEIGHT_BASE: wbs_dat_o <= cfg_o.weight_base;
                REG_IFMAP_BASE:  wbs_dat_o <= cfg_o.ifmap_base;
                REG_OPSUM_BASE:  wbs_dat_o <= cfg_o.opsum_base;
                REG_ROWS:        wbs_dat_o <= DATA_W'(cfg_o.rows);
                default:         wbs_dat_o <= '0;
            endcase
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst_i)
        wbs_ack_o |=> !wbs_ack_o);

endmodule

// ==== rtl/glb_arbiter.sv ====
// GLB arbiter and wishbone classic master
// weight wins outright, ifmap and opsum share by round robin,
// one transaction in flight at a time
`timescale 1ns/10ps

module glb_arbiter (
    input  logic                         clk,
    input  logic                         rst_i,
    input  token_pkg::glb_req_t          weight_req_i,
    input  token_pkg::glb_req_t          ifmap_req_i,
    input  token_pkg::glb_req_t          opsum_req_i,
    output token_pkg::glb_rsp_t          weight_rsp_o,
    output token_pkg::glb_rsp_t          ifmap_rsp_o,
    output token_pkg::glb_rsp_t          opsum_rsp_o,
    output logic                         glb_cyc_o,
    output logic                         glb_stb_o,
    output logic                         glb_we_o,
    output logic [token_pkg::ADDR_W-1:0] glb_adr_o,
    output logic [3:0]                   glb_sel_o,
    output logic [token_pkg::DATA_W-1:0] glb_dat_o,
    input  logic [token_pkg::DATA_W-1:0] glb_dat_i,
    input  logic                         glb_ack_i
);
    import token_pkg::*;

    typedef enum logic [1:0] {OWN_NONE, OWN_W, OWN_I, OWN_O} owner_t;

    owner_t   owner_q;
    owner_t   grant;
    glb_req_t sel_req;
    logic     rr_q;   // 0 favours ifmap, 1 favours opsum

    always_comb begin
        grant   = OWN_NONE;
        sel_req = weight_req_i;
        if (weight_req_i.req) begin
            grant = OWN_W;
        end else if (ifmap_req_i.req && (!opsum_req_i.req || !rr_q)) begin
            grant   = OWN_I;
            sel_req = ifmap_req_i;
        end else if (opsum_req_i.req) begin
            grant   = OWN_O;
            sel_req = opsum_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            owner_q   <= OWN_NONE;
            rr_q      <= 1'b0;
            glb_cyc_o <= 1'b0;
            glb_stb_o <= 1'b0;
        end else if (owner_q == OWN_NONE) begin
            if (grant != OWN_NONE) begin
                owner_q   <= grant;
                glb_cyc_o <= 1'b1;
                glb_stb_o <= 1'b1;
                if (grant == OWN_I) rr_q <= 1'b1;
                if (grant == OWN_O) rr_q <= 1'b0;
            end
        end else if (glb_ack_i) begin
            owner_q   <= OWN_NONE;
            glb_cyc_o <= 1'b0;
            glb_stb_o <= 1'b0;
        end
    end

    // latch the granted request for the whole bus cycle
    always_ff @(posedge clk) begin
        if (owner_q == OWN_NONE && grant != OWN_NONE) begin
            glb_we_o  <= sel_req.we;
            glb_adr_o <= sel_req.addr << 2;  // word to byte address
            glb_dat_o <= sel_req.wdata;
        end
    end

    assign glb_sel_o = 4'hf;

    // ack and read data go back to the owner only
    always_comb begin
        weight_rsp_o = '0;
        ifmap_rsp_o  = '0;
        opsum_rsp_o  = '0;
        case (owner_q)
            OWN_W: weight_rsp_o = '{ack: glb_ack_i, rdata: glb_dat_i};
            OWN_I: ifmap_rsp_o  = '{ack: glb_ack_i, rdata: glb_dat_i};
            OWN_O: opsum_rsp_o  = '{ack: glb_ack_i, rdata: glb_dat_i};
            default: ;
        endcase
    end

    a_master_stable: assert property (@(posedge clk) disable iff (rst_i)
        glb_stb_o && !glb_ack_i |=> $stable({glb_cyc_o, glb_stb_o, glb_we_o, glb_adr_o, glb_dat_o}));

endmodule

// ==== rtl/ifmap_feeder.sv ====
// ifmap feeder
// walks rows and lanes, reads each ifmap word from GLB and pushes it
// into its lane FIFO, holding while that lane is full
`timescale 1ns/10ps

module ifmap_feeder #(
    parameter int LANES = 4
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         stream_phase_i,
    input  token_pkg::pass_cfg_t         cfg_i,
    output token_pkg::glb_req_t          req_o,
    input  token_pkg::glb_rsp_t          rsp_i,
    input  logic [LANES-1:0]             ifmap_full_i,
    output logic [LANES-1:0]             ifmap_push_o,
    output logic [token_pkg::DATA_W-1:0] ifmap_push_data_o,
    output logic                         done_o
);
    import token_pkg::*;

    localparam int LW = (LANES > 1) ? $clog2(LANES) : 1;

    typedef enum logic [2:0] {F_IDLE, F_CHK, F_REQ, F_PUSH, F_FIN} state_t;

    state_t            state_q;
    logic [ROW_W-1:0]  row_q;
    logic [LW-1:0]     lane_q;
    logic [DATA_W-1:0] data_q;
    logic              lane_full;
    logic              last;

    assign lane_full = ifmap_full_i[lane_q];
    assign last      = (row_q == cfg_i.rows - ROW_W'(1)) && (lane_q == LW'(LANES - 1));

    // {row, lane} is r*LANES + l for power-of-two lanes
    assign req_o.req   = (state_q == F_REQ);
    assign req_o.we    = 1'b0;
    assign req_o.addr  = cfg_i.ifmap_base + ADDR_W'({row_q, lane_q});
    assign req_o.wdata = '0;

    assign ifmap_push_o      = (state_q == F_PUSH && !lane_full) ? (LANES'(1) << lane_q) : '0;
    assign ifmap_push_data_o = data_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= F_IDLE;
            row_q   <= '0;
            lane_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                F_IDLE: if (stream_phase_i) begin
                    row_q  <= '0;
                    lane_q <= '0;
                    if (cfg_i.rows == '0) begin
                        done_o  <= 1'b1;  // nothing to move
                        state_q <= F_FIN;
                    end else begin
                        state_q <= F_CHK;
                    end
                end
                F_CHK: if (!lane_full) state_q <= F_REQ;   // no read toward a full lane
                F_REQ: if (rsp_i.ack) state_q <= F_PUSH;
                F_PUSH: if (!lane_full) begin
                    if (last) begin
                        done_o  <= 1'b1;
                        state_q <= F_FIN;
                    end else begin
                        lane_q  <= lane_q + 1'b1;  // wraps at LANES
                        if (lane_q == LW'(LANES - 1)) row_q <= row_q + 1'b1;
                        state_q <= F_CHK;
                    end
                end
                default: if (!stream_phase_i) state_q <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == F_REQ && rsp_i.ack) data_q <= rsp_i.rdata.word;
    end

    a_push_legal: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(ifmap_push_o) && !(|(ifmap_push_o & ifmap_full_i)));

endmodule

// ==== rtl/opsum_drainer.sv ====
// opsum drainer
// pops lane opsum FIFOs row by row, lane by lane, and writes each word to GLB
`timescale 1ns/10ps

module opsum_drainer #(
    parameter int LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    stream_phase_i,
    input  token_pkg::pass_cfg_t                    cfg_i,
    output logic [LANES-1:0]                        opsum_pop_o,
    input  logic [LANES-1:0]                        opsum_empty_i,
    input  logic [LANES-1:0][token_pkg::DATA_W-1:0] opsum_pop_data_i,
    output token_pkg::glb_req_t                     req_o,
    input  token_pkg::glb_rsp_t                     rsp_i,
    output logic                                    done_o
);
    import token_pkg::*;

    localparam int LW = (LANES > 1) ? $clog2(LANES) : 1;

    typedef enum logic [1:0] {D_IDLE, D_POP, D_REQ, D_FIN} state_t;

    state_t            state_q;
    logic [ROW_W-1:0]  row_q;
    logic [LW-1:0]     lane_q;
    logic [DATA_W-1:0] data_q;
    logic              lane_empty;
    logic              last;

    assign lane_empty = opsum_empty_i[lane_q];
    assign last       = (row_q == cfg_i.rows - ROW_W'(1)) && (lane_q == LW'(LANES - 1));

    assign opsum_pop_o = (state_q == D_POP && !lane_empty) ? (LANES'(1) << lane_q) : '0;

    assign req_o.req   = (state_q == D_REQ);
    assign req_o.we    = 1'b1;
    assign req_o.addr  = cfg_i.opsum_base + ADDR_W'({row_q, lane_q});
    assign req_o.wdata = data_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= D_IDLE;
            row_q   <= '0;
            lane_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                D_IDLE: if (stream_phase_i) begin
                    row_q  <= '0;
                    lane_q <= '0;
                    if (cfg_i.rows == '0) begin
                        done_o  <= 1'b1;
                        state_q <= D_FIN;
                    end else begin
                        state_q <= D_POP;
                    end
                end
                D_POP: if (!lane_empty) state_q <= D_REQ;  // empty lane stalls here
                D_REQ: if (rsp_i.ack) begin
                    if (last) begin
                        done_o  <= 1'b1;
                        state_q <= D_FIN;
                    end else begin
                        lane_q  <= lane_q + 1'b1;
                        if (lane_q == LW'(LANES - 1)) row_q <= row_q + 1'b1;
                        state_q <= D_POP;
                    end
                end
                default: if (!stream_phase_i) state_q <= D_IDLE;
            endcase
        end
    end

    // show-ahead FIFO, word is valid during the pop cycle
    always_ff @(posedge clk) begin
        if (state_q == D_POP && !lane_empty) data_q <= opsum_pop_data_i[lane_q];
    end

    a_no_empty_pop: assert property (@(posedge clk) disable iff (rst_i)
        !(|(opsum_pop_o & opsum_empty_i)));

endmodule

// ==== rtl/pass_sequencer.sv ====
// pass sequencer
// steps idle -> weight load -> stream -> done for one layer pass
`timescale 1ns/10ps

module pass_sequencer (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    output logic busy_o,
    output logic weight_phase_o,
    input  logic weight_done_i,
    output logic stream_phase_o,
    input  logic ifmap_done_i,
    input  logic opsum_done_i,
    output logic pass_done_o
);

    typedef enum logic [1:0] {S_IDLE, S_WEIGHT, S_STREAM, S_DONE} state_t;

    state_t state_q;
    logic   ifmap_seen_q;
    logic   opsum_seen_q;
    logic   ifmap_fin;
    logic   opsum_fin;

    // the two stream movers finish in either order
    assign ifmap_fin = ifmap_seen_q || ifmap_done_i;
    assign opsum_fin = opsum_seen_q || opsum_done_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= S_IDLE;
            ifmap_seen_q <= 1'b0;
            opsum_seen_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    ifmap_seen_q <= 1'b0;
                    opsum_seen_q <= 1'b0;
                    if (start_i) state_q <= S_WEIGHT;   // start only honoured here
                end
                S_WEIGHT: if (weight_done_i) state_q <= S_STREAM;
                S_STREAM: begin
                    ifmap_seen_q <= ifmap_fin;
                    opsum_seen_q <= opsum_fin;
                    if (ifmap_fin && opsum_fin) state_q <= S_DONE;
                end
                default: state_q <= S_IDLE;  // S_DONE lasts one cycle
            endcase
        end
    end

    assign busy_o         = (state_q != S_IDLE);
    assign weight_phase_o = (state_q == S_WEIGHT);
    assign stream_phase_o = (state_q == S_STREAM);
    assign pass_done_o    = (state_q == S_DONE);

endmodule

// ==== rtl/token_engine.sv ====
// token engine top
// host register block, pass sequencer, weight/ifmap/opsum movers
// and the shared GLB master
`timescale 1ns/10ps

module token_engine #(
    parameter int LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    wbs_cyc_i,
    input  logic                                    wbs_stb_i,
    input  logic                                    wbs_we_i,
    input  logic [2:0]                              wbs_adr_i,
    input  logic [token_pkg::DATA_W-1:0]            wbs_dat_i,
    output logic [token_pkg::DATA_W-1:0]            wbs_dat_o,
    output logic                                    wbs_ack_o,
    output logic                                    glb_cyc_o,
    output logic                                    glb_stb_o,
    output logic                                    glb_we_o,
    output logic [token_pkg::ADDR_W-1:0]            glb_adr_o,
    output logic [3:0]                              glb_sel_o,
    output logic [token_pkg::DATA_W-1:0]            glb_dat_o,
    input  logic [token_pkg::DATA_W-1:0]            glb_dat_i,
    input  logic                                    glb_ack_i,
    output token_pkg::weight_load_t                 weight_load_o,
    output logic [LANES-1:0]                        ifmap_push_o,
    output logic [token_pkg::DATA_W-1:0]            ifmap_push_data_o,
    input  logic [LANES-1:0]                        ifmap_full_i,
    output logic [LANES-1:0]                        opsum_pop_o,
    input  logic [LANES-1:0]                        opsum_empty_i,
    input  logic [LANES-1:0][token_pkg::DATA_W-1:0] opsum_pop_data_i
);
    import token_pkg::*;

    pass_cfg_t cfg;
    logic      start, busy, pass_done;
    logic      weight_phase, stream_phase;
    logic      weight_done, ifmap_done, opsum_done;
    glb_req_t  weight_req, ifmap_req, opsum_req;
    glb_rsp_t  weight_rsp, ifmap_rsp, opsum_rsp;

    cfg_regs u_cfg_regs (
        .clk(clk), .rst_i(rst_i),
        .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
        .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
        .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
        .busy_i(busy), .pass_done_i(pass_done),
        .cfg_o(cfg), .start_o(start)
    );

    pass_sequencer u_pass_sequencer (
        .clk(clk), .rst_i(rst_i),
        .start_i(start), .busy_o(busy),
        .weight_phase_o(weight_phase), .weight_done_i(weight_done),
        .stream_phase_o(stream_phase),
        .ifmap_done_i(ifmap_done), .opsum_done_i(opsum_done),
        .pass_done_o(pass_done)
    );

    weight_loader #(.LANES(LANES)) u_weight_loader (
        .clk(clk), .rst_i(rst_i),
        .weight_phase_i(weight_phase), .cfg_i(cfg),
        .req_o(weight_req), .rsp_i(weight_rsp),
        .weight_load_o(weight_load_o), .done_o(weight_done)
    );

    ifmap_feeder #(.LANES(LANES)) u_ifmap_feeder (
        .clk(clk), .rst_i(rst_i),
        .stream_phase_i(stream_phase), .cfg_i(cfg),
        .req_o(ifmap_req), .rsp_i(ifmap_rsp),
        .ifmap_full_i(ifmap_full_i), .ifmap_push_o(ifmap_push_o),
        .ifmap_push_data_o(ifmap_push_data_o), .done_o(ifmap_done)
    );

    opsum_drainer #(.LANES(LANES)) u_opsum_drainer (
        .clk(clk), .rst_i(rst_i),
        .stream_phase_i(stream_phase), .cfg_i(cfg),
        .opsum_pop_o(opsum_pop_o), .opsum_empty_i(opsum_empty_i),
        .opsum_pop_data_i(opsum_pop_data_i),
        .req_o(opsum_req), .rsp_i(opsum_rsp), .done_o(opsum_done)
    );

    glb_arbiter u_glb_arbiter (
        .clk(clk), .rst_i(rst_i),
        .weight_req_i(weight_req), .ifmap_req_i(ifmap_req), .opsum_req_i(opsum_req),
        .weight_rsp_o(weight_rsp), .ifmap_rsp_o(ifmap_rsp), .opsum_rsp_o(opsum_rsp),
        .glb_cyc_o(glb_cyc_o), .glb_stb_o(glb_stb_o), .glb_we_o(glb_we_o),
        .glb_adr_o(glb_adr_o), .glb_sel_o(glb_sel_o), .glb_dat_o(glb_dat_o),
        .glb_dat_i(glb_dat_i), .glb_ack_i(glb_ack_i)
    );

endmodule

// ==== rtl/token_pkg.sv ====
// token engine shared definitions
// widths, register map and the structs passed between the data movers
package token_pkg;

    parameter int DATA_W   = 32;
    parameter int ADDR_W   = 32;
    parameter int ROW_W    = 16;
    parameter int PE_ROW_W = 3;   // enough for up to 8 lanes

    // register word offsets
    parameter logic [2:0] REG_CTRL        = 3'd0;  // bit 0 start
    parameter logic [2:0] REG_STATUS      = 3'd1;  // bit 0 busy, bit 1 done
    parameter logic [2:0] REG_WEIGHT_BASE = 3'd2;
    parameter logic [2:0] REG_IFMAP_BASE  = 3'd3;
    parameter logic [2:0] REG_OPSUM_BASE  = 3'd4;
    parameter logic [2:0] REG_ROWS        = 3'd5;

    // one GLB word, seen whole or as four PE column bytes
    typedef union packed {
        logic [DATA_W-1:0]  word;
        logic [3:0][7:0]    bytes;   // byte 0 in the low bits
    } weight_word_u;

    typedef struct packed {
        logic               req;
        logic               we;
        logic [ADDR_W-1:0]  addr;   // word address
        logic [DATA_W-1:0]  wdata;
    } glb_req_t;

    typedef struct packed {
        logic               ack;
        weight_word_u       rdata;
    } glb_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  weight_base;
        logic [ADDR_W-1:0]  ifmap_base;
        logic [ADDR_W-1:0]  opsum_base;
        logic [ROW_W-1:0]   rows;
    } pass_cfg_t;

    typedef struct packed {
        logic                 en;
        logic [PE_ROW_W-1:0]  row;
        weight_word_u         data;
    } weight_load_t;

endpackage

// ==== rtl/weight_loader.sv ====
// weight loader
// fetches one GLB word per PE row and pulses the row's weight load
`timescale 1ns/10ps

module weight_loader #(
    parameter int LANES = 4
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    weight_phase_i,
    input  token_pkg::pass_cfg_t    cfg_i,
    output token_pkg::glb_req_t     req_o,
    input  token_pkg::glb_rsp_t     rsp_i,
    output token_pkg::weight_load_t weight_load_o,
    output logic                    done_o
);
    import token_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_REQ, W_FIN} state_t;

    state_t              state_q;
    logic [PE_ROW_W-1:0] row_q;
    logic                en_q;
    logic [PE_ROW_W-1:0] row_out_q;
    weight_word_u        data_q;
    logic                got_word;

    assign got_word = (state_q == W_REQ) && rsp_i.ack;

    assign req_o.req   = (state_q == W_REQ);
    assign req_o.we    = 1'b0;
    assign req_o.addr  = cfg_i.weight_base + ADDR_W'(row_q);
    assign req_o.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= W_IDLE;
            row_q   <= '0;
            en_q    <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            en_q   <= got_word;
            done_o <= 1'b0;
            case (state_q)
                W_IDLE: if (weight_phase_i) begin
                    row_q   <= '0;
                    state_q <= W_REQ;
                end
                W_REQ: if (rsp_i.ack) begin
                    if (row_q == PE_ROW_W'(LANES - 1)) begin
                        done_o  <= 1'b1;   // lines up with the last en
                        state_q <= W_FIN;
                    end else begin
                        row_q <= row_q + 1'b1;
                    end
                end
                default: if (!weight_phase_i) state_q <= W_IDLE;  // hold until phase drops
            endcase
        end
    end

    // byte c of the word feeds PE column c
    always_ff @(posedge clk) begin
        if (got_word) begin
            row_out_q <= row_q;
            for (int c = 0; c < 4; c++) begin
                data_q.bytes[c] <= rsp_i.rdata.bytes[c];
            end
        end
    end

    assign weight_load_o.en   = en_q;
    assign weight_load_o.row  = row_out_q;
    assign weight_load_o.data = data_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the token engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_token_engine -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== sources.f ====
rtl/token_pkg.sv
rtl/cfg_regs.sv
rtl/pass_sequencer.sv
rtl/weight_loader.sv
rtl/ifmap_feeder.sv
rtl/opsum_drainer.sv
rtl/glb_arbiter.sv
rtl/token_engine.sv
dv/tb_clock_gen.sv
dv/tb_token_engine.sv
